/* Bender.yml */
package:
  name: diad

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/diad_pkg.sv
      - verilog/mem.sv
      - pipeline/stg1_fetch.sv
      - pipeline/stg2_decode.sv
      - pipeline/stg3_execute.sv
      - pipeline/stg4_memory.sv
      - pipeline/stg5_retire.sv
      - verilog/diad.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/diad_tb.sv

/* common/diad_pkg.sv */
`include "diad_settings.svh"

package diad_pkg;

    typedef logic [`SIZE_ADDR-1:0] addr_t;
    typedef logic [`SIZE_PC-1:0]   pc_t;
    typedef logic [`SIZE_DATA-1:0] word_t;
    typedef logic [`SIZE_REG-1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        opc_nop  = 4'd0,
        opc_add  = 4'd1,
        opc_sub  = 4'd2,
        opc_and  = 4'd3,
        opc_or   = 4'd4,
        opc_xor  = 4'd5,
        opc_addi = 4'd6,
        opc_ldi  = 4'd7,
        opc_ld   = 4'd8,
        opc_st   = 4'd9,
        opc_shl  = 4'd10
    } opc_e;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } fetch_item_t;

    typedef struct packed {
        logic                valid;
        pc_t                 pc;
        word_t               instr;
        opc_e                opc;
        reg_idx_t            rd;
        logic                wr_en;
        word_t               op_a; // rs, or imm9 for LDI
        word_t               op_b; // rt, or rd for ST
        logic [`SIZE_PC-1:0] imm;  // imm6 sign extended to offset width
    } dec_item_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        word_t    instr;
        opc_e     opc;
        reg_idx_t rd;
        logic     wr_en;
        word_t    result;
        addr_t    addr;
        word_t    st_data;
    } exe_item_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        word_t    instr;
        logic     wr_en;
        reg_idx_t rd;
        word_t    value;
        logic     st_en;
        addr_t    st_addr;
        word_t    st_data;
    } retire_t;

endpackage

/* common/diad_settings.svh */
`ifndef DIAD_SETTINGS_SVH
`define DIAD_SETTINGS_SVH

// Memory word address
`define SIZE_ADDR 8

// Code half only
`define SIZE_PC 7

`define SIZE_DATA 16

`define SIZE_REG 3

`define MEM_WORDS 256

// First word of the data half
`define DATA_BASE 128

`endif

/* pipeline/stg1_fetch.sv */
`timescale 1ns/10ps

module stg1_fetch
    import diad_pkg::*;
(
    input  logic        iw_clk,
    input  logic        iw_rst,
    input  logic        stall,
    output logic        inst_en,
    output pc_t         inst_addr,
    input  word_t       inst_rdata,
    output fetch_item_t fetch
);
    pc_t  pc;
    pc_t  rd_pc;    // Address of the read in flight
    logic rd_valid;

    assign inst_en   = ~stall;
    assign inst_addr = pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc       <= '0;
            rd_pc    <= '0;
            rd_valid <= 1'b0;
        end
        else if (!stall) begin
            pc       <= pc + pc_t'(1); // Wraps inside the code half
            rd_pc    <= pc;
            rd_valid <= 1'b1;
        end
    end

    assign fetch = '{
        valid: rd_valid,
        pc:    rd_pc,
        instr: inst_rdata
    };
endmodule

/* pipeline/stg2_decode.sv */
`timescale 1ns/10ps
`include "diad_settings.svh"

module stg2_decode
    import diad_pkg::*;
(
    input  logic        iw_clk,
    input  logic        iw_rst,
    input  fetch_item_t fetch,
    output logic        stall,
    input  reg_idx_t    ex_rd,
    input  logic        ex_wr,
    input  reg_idx_t    ma_rd,
    input  logic        ma_wr,
    input  logic        rf_we,
    input  reg_idx_t    rf_idx,
    input  word_t       rf_data,
    output dec_item_t   dec
);
    word_t     regs [0:(1 << `SIZE_REG)-1];
    opc_e      opc;
    reg_idx_t  rd;
    reg_idx_t  rs;
    reg_idx_t  rt;
    logic      use_rs;
    logic      use_rt;
    logic      use_rd;
    logic      writes;
    dec_item_t dec_d;

    // Retire write shows up in the same cycle
    function automatic word_t rf_read(input reg_idx_t idx);
        return (rf_we && rf_idx == idx) ? rf_data : regs[idx];
    endfunction

    function automatic logic busy(input reg_idx_t idx);
        return (ex_wr && ex_rd == idx) || (ma_wr && ma_rd == idx);
    endfunction

    assign opc = opc_e'(fetch.instr[15:12]);
    assign rd  = fetch.instr[11:9];
    assign rs  = fetch.instr[8:6];
    assign rt  = fetch.instr[5:3];

    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        use_rd = 1'b0;
        writes = 1'b0;
        case (opc)
            opc_add, opc_sub, opc_and, opc_or, opc_xor, opc_shl: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                writes = 1'b1;
            end
            opc_addi, opc_ld: begin
                use_rs = 1'b1;
                writes = 1'b1;
            end
            opc_ldi: writes = 1'b1;
            opc_st: begin
                use_rs = 1'b1;
                use_rd = 1'b1; // Store data comes from rd
            end
            default: ;         // Undefined opcodes act as NOP
        endcase
    end

    always_comb begin
        stall = fetch.valid && ((use_rs && busy(rs)) || (use_rt && busy(rt))
                                || (use_rd && busy(rd)));
    end

    always_comb begin
        dec_d.valid = fetch.valid && !stall;
        dec_d.pc    = fetch.pc;
        dec_d.instr = fetch.instr;
        dec_d.opc   = opc;
        dec_d.rd    = rd;
        dec_d.wr_en = writes && dec_d.valid;
        dec_d.op_a  = (opc == opc_ldi) ? word_t'(fetch.instr[8:0]) : rf_read(rs);
        dec_d.op_b  = (opc == opc_st) ? rf_read(rd) : rf_read(rt);
        dec_d.imm   = {fetch.instr[5], fetch.instr[5:0]};
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < (1 << `SIZE_REG); i++) begin
                regs[i] <= '0;
            end
        end
        else if (rf_we) begin
            regs[rf_idx] <= rf_data;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec <= '0;
        end
        else begin
            dec <= dec_d; // Bubble while stalled
        end
    end

    // Writer leaves execute and memory within two cycles
    a_stall_bound: assert property (@(posedge iw_clk) disable iff (iw_rst)
        stall [*2] |=> !stall);
endmodule

/* pipeline/stg3_execute.sv */
`timescale 1ns/10ps
`include "diad_settings.svh"

module stg3_execute
    import diad_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  dec_item_t dec,
    output exe_item_t exe
);
    word_t               imm_ext;
    logic [`SIZE_PC-1:0] offset;
    exe_item_t           exe_d;

    assign imm_ext = word_t'($signed(dec.imm));
    assign offset  = dec.op_a[`SIZE_PC-1:0] + dec.imm; // Data half wraps

    always_comb begin
        exe_d.valid   = dec.valid;
        exe_d.pc      = dec.pc;
        exe_d.instr   = dec.instr;
        exe_d.opc     = dec.opc;
        exe_d.rd      = dec.rd;
        exe_d.wr_en   = dec.wr_en;
        exe_d.addr    = addr_t'(`DATA_BASE) + addr_t'(offset);
        exe_d.st_data = dec.op_b;
        case (dec.opc)
            opc_add:  exe_d.result = dec.op_a + dec.op_b;
            opc_sub:  exe_d.result = dec.op_a - dec.op_b;
            opc_and:  exe_d.result = dec.op_a & dec.op_b;
            opc_or:   exe_d.result = dec.op_a | dec.op_b;
            opc_xor:  exe_d.result = dec.op_a ^ dec.op_b;
            opc_addi: exe_d.result = dec.op_a + imm_ext;
            opc_ldi:  exe_d.result = dec.op_a;
            opc_shl:  exe_d.result = dec.op_a << dec.op_b[3:0];
            default:  exe_d.result = '0; // LD fills in at retire
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            exe <= '0;
        end
        else begin
            exe <= exe_d;
        end
    end
endmodule

/* pipeline/stg4_memory.sv */
`timescale 1ns/10ps

module stg4_memory
    import diad_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  exe_item_t exe,
    output logic      data_we,
    output addr_t     data_addr,
    output word_t     data_wdata,
    output exe_item_t mem_item
);
    // Read is always issued, LD picks it up next cycle
    assign data_we    = exe.valid && (exe.opc == opc_st);
    assign data_addr  = exe.addr;
    assign data_wdata = exe.st_data;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mem_item <= '0;
        end
        else begin
            mem_item <= exe;
        end
    end
endmodule

/* pipeline/stg5_retire.sv */
`timescale 1ns/10ps

module stg5_retire
    import diad_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  exe_item_t mem_item,
    input  word_t     data_rdata,
    output logic      rf_we,
    output reg_idx_t  rf_idx,
    output word_t     rf_data,
    output retire_t   retire
);
    word_t value;

    assign value   = (mem_item.opc == opc_ld) ? data_rdata : mem_item.result;
    assign rf_we   = mem_item.wr_en; // Already gated by valid in decode
    assign rf_idx  = mem_item.rd;
    assign rf_data = value;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire <= '0;
        end
        else begin
            retire.valid   <= mem_item.valid;
            retire.pc      <= mem_item.pc;
            retire.instr   <= mem_item.instr;
            retire.wr_en   <= mem_item.wr_en;
            retire.rd      <= mem_item.rd;
            retire.value   <= value;
            retire.st_en   <= mem_item.valid && (mem_item.opc == opc_st);
            retire.st_addr <= mem_item.addr;
            retire.st_data <= mem_item.st_data;
        end
    end

    a_wr_valid: assert property (@(posedge iw_clk) disable iff (iw_rst)
        retire.wr_en |-> retire.valid);
endmodule

/* project.f */
+incdir+common
common/diad_pkg.sv
verilog/mem.sv
pipeline/stg1_fetch.sv
pipeline/stg2_decode.sv
pipeline/stg3_execute.sv
pipeline/stg4_memory.sv
pipeline/stg5_retire.sv
verilog/diad.sv
verification/diad_tb.sv

/* verification/diad_tb.sv */
`timescale 1ns/10ps
`include "diad_settings.svh"

module diad_tb
    import diad_pkg::*;
();
    localparam int NUM_RETIRES = 320;
    localparam int RETIRE_TIMEOUT = 20;

    logic    iw_clk;
    logic    iw_rst;
    logic    load_we;
    addr_t   load_addr;
    word_t   load_data;
    retire_t trace;

    logic [31:0] lcg_state;
    word_t       model_mem [0:`MEM_WORDS-1];
    word_t       model_regs [0:(1 << `SIZE_REG)-1];
    pc_t         exp_pc;
    int          num_ld;
    int          num_st;

    diad dut_i (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .load_we  (load_we),
        .load_addr(load_addr),
        .load_data(load_data),
        .retire   (trace)
    );

    always #50 iw_clk = ~iw_clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h exp 0x%h", name, got, exp);
            fail_run("retired word differs from the model");
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("MISMATCH retire.pc got 0x%h exp 0x%h", got, exp);
            fail_run("instructions retired out of program order");
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH retire.rd got 0x%h exp 0x%h", got, exp);
            fail_run("wrong destination register");
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h exp 0x%h", name, got, exp);
            fail_run("wrong data address");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h exp 0x%h", name, got, exp);
            fail_run("wrong control bit in the retire trace");
        end
    endtask

    // Random word, biased toward loads and stores, with forced register reuse
    function automatic word_t make_instr(input reg_idx_t prev_rd, input int slot);
        word_t w;
        word_t r;
        w = lcg_next();
        r = lcg_next();
        if (r[2:0] == 3'd0) begin
            w[15:12] = opc_ld;
        end
        else if (r[2:0] == 3'd1) begin
            w[15:12] = opc_st;
        end
        if (slot % 4 == 3) begin
            w[8:6] = prev_rd; // Reads the previous result right away
        end
        if (slot % 8 == 7) begin
            w[5:3] = prev_rd;
        end
        return w;
    endfunction

    task automatic load_memory();
        reg_idx_t prev_rd;
        word_t    w;
        prev_rd = '0;
        for (int a = 0; a < `MEM_WORDS; a++) begin
            if (a < `DATA_BASE) begin
                w = make_instr(prev_rd, a);
                prev_rd = w[11:9];
            end
            else begin
                w = lcg_next();
            end
            model_mem[a] = w;
            @(negedge iw_clk);
            load_we   = 1'b1;
            load_addr = addr_t'(a);
            load_data = w;
        end
        @(negedge iw_clk);
        load_we = 1'b0;
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        while (!trace.valid && cycles < RETIRE_TIMEOUT) begin
            @(negedge iw_clk);
            cycles++;
        end
        if (!trace.valid) begin
            fail_run("no instruction retired within the timeout");
        end
    endtask

    // Steps the model by one instruction and compares the trace with it
    task automatic step_and_check();
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    imm_ext;
        word_t    exp_val;
        reg_idx_t rd;
        addr_t    ea;
        logic     exp_wr;
        logic     exp_st;
        instr   = model_mem[exp_pc];
        rd      = instr[11:9];
        a       = model_regs[instr[8:6]];
        b       = model_regs[instr[5:3]];
        imm_ext = {{10{instr[5]}}, instr[5:0]};
        ea      = addr_t'(`DATA_BASE + ((a + imm_ext) & 16'h007f));
        exp_val = '0;
        exp_wr  = 1'b1;
        exp_st  = 1'b0;
        case (opc_e'(instr[15:12]))
            opc_add:  exp_val = a + b;
            opc_sub:  exp_val = a - b;
            opc_and:  exp_val = a & b;
            opc_or:   exp_val = a | b;
            opc_xor:  exp_val = a ^ b;
            opc_addi: exp_val = a + imm_ext;
            opc_ldi:  exp_val = {7'd0, instr[8:0]};
            opc_shl:  exp_val = a << b[3:0];
            opc_ld:   exp_val = model_mem[ea];
            opc_st: begin
                exp_wr = 1'b0;
                exp_st = 1'b1;
            end
            default:  exp_wr = 1'b0; // NOP and undefined codes
        endcase
        check_pc(trace.pc, exp_pc);
        check_word("retire.instr", trace.instr, instr);
        check_flag("retire.wr_en", trace.wr_en, exp_wr);
        check_flag("retire.st_en", trace.st_en, exp_st);
        if (exp_wr) begin
            check_reg(trace.rd, rd);
            check_word("retire.value", trace.value, exp_val);
            model_regs[rd] = exp_val;
            if (instr[15:12] == opc_ld) begin
                num_ld++;
            end
        end
        if (exp_st) begin
            check_addr("retire.st_addr", trace.st_addr, ea);
            check_word("retire.st_data", trace.st_data, model_regs[rd]);
            model_mem[ea] = model_regs[rd];
            num_st++;
        end
        exp_pc = exp_pc + pc_t'(1);
    endtask

    initial begin
        iw_clk    = 1'b0;
        iw_rst    = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lcg_state = 32'd9209;
        exp_pc    = '0;
        num_ld    = 0;
        num_st    = 0;
        for (int i = 0; i < (1 << `SIZE_REG); i++) begin
            model_regs[i] = '0;
        end

        load_memory(); // Core held in reset while the image goes in
        repeat (16) @(negedge iw_clk);
        check_flag("retire.valid", trace.valid, 1'b0);
        iw_rst = 1'b0;

        for (int n = 0; n < NUM_RETIRES; n++) begin
            wait_retire();
            step_and_check();
            @(negedge iw_clk);
        end

        $display("%0d retirements, %0d loads, %0d stores", NUM_RETIRES, num_ld, num_st);
        $display("Verification passed");
        $finish;
    end
endmodule

/* verilog/diad.sv */
`timescale 1ns/10ps

module diad
    import diad_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  logic    load_we,
    input  addr_t   load_addr,
    input  word_t   load_data,
    output retire_t retire
);
    logic        w_inst_en;
    pc_t         w_inst_addr;
    word_t       w_inst_rdata;
    logic        w_data_we;
    addr_t       w_data_addr;
    word_t       w_data_wdata;
    word_t       w_data_rdata;
    logic        w_stall;
    fetch_item_t w_fetch;
    dec_item_t   w_dec;
    exe_item_t   w_exe;
    exe_item_t   w_mem_item;
    logic        w_rf_we;
    reg_idx_t    w_rf_idx;
    word_t       w_rf_data;

    mem u_mem (
        .iw_clk    (iw_clk),
        .inst_en   (w_inst_en),
        .inst_addr (w_inst_addr),
        .inst_rdata(w_inst_rdata),
        .data_we   (w_data_we),
        .data_addr (w_data_addr),
        .data_wdata(w_data_wdata),
        .data_rdata(w_data_rdata),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    stg1_fetch u_stg1_fetch (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .stall     (w_stall),
        .inst_en   (w_inst_en),
        .inst_addr (w_inst_addr),
        .inst_rdata(w_inst_rdata),
        .fetch     (w_fetch)
    );

    stg2_decode u_stg2_decode (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .fetch  (w_fetch),
        .stall  (w_stall),
        .ex_rd  (w_dec.rd),     // Writer in execute
        .ex_wr  (w_dec.wr_en),
        .ma_rd  (w_exe.rd),     // Writer in memory access
        .ma_wr  (w_exe.wr_en),
        .rf_we  (w_rf_we),
        .rf_idx (w_rf_idx),
        .rf_data(w_rf_data),
        .dec    (w_dec)
    );

    stg3_execute u_stg3_execute (
        .iw_clk(iw_clk),
        .iw_rst(iw_rst),
        .dec   (w_dec),
        .exe   (w_exe)
    );

    stg4_memory u_stg4_memory (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .exe       (w_exe),
        .data_we   (w_data_we),
        .data_addr (w_data_addr),
        .data_wdata(w_data_wdata),
        .mem_item  (w_mem_item)
    );

    stg5_retire u_stg5_retire (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .mem_item  (w_mem_item),
        .data_rdata(w_data_rdata),
        .rf_we     (w_rf_we),
        .rf_idx    (w_rf_idx),
        .rf_data   (w_rf_data),
        .retire    (retire)
    );
endmodule

/* verilog/mem.sv */
`timescale 1ns/10ps
`include "diad_settings.svh"

module mem
    import diad_pkg::*;
(
    input  logic  iw_clk,
    input  logic  inst_en,
    input  pc_t   inst_addr,
    output word_t inst_rdata,
    input  logic  data_we,
    input  addr_t data_addr,
    input  word_t data_wdata,
    output word_t data_rdata,
    input  logic  load_we,
    input  addr_t load_addr,
    input  word_t load_data
);
    word_t ram [0:`MEM_WORDS-1];
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;

    assign wr_en   = load_we | data_we;
    assign wr_addr = load_we ? load_addr : data_addr; // Program load wins
    assign wr_data = load_we ? load_data : data_wdata;

    always_ff @(posedge iw_clk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
        if (inst_en) begin
            inst_rdata <= ram[addr_t'(inst_addr)]; // Held while fetch stalls
        end
        data_rdata <= ram[data_addr];
    end

    // Program load only happens while the core is in reset
    a_one_writer: assert property (@(posedge iw_clk) !(load_we && data_we));
endmodule
